// File: hdl/imageBlockPkg.sv
package imageBlockPkg;

  //////////////////////////////
  // geometry
  //////////////////////////////

  // pixels per block side
  localparam int BlockSize = 16;
  localparam int BytesPerPixel = 2;
  // one bus beat carries four pixels
  localparam int PixelsPerBeat = 4;
  localparam int BeatsPerLine = BlockSize / PixelsPerBeat;
  // one whole block, line then beat
  localparam int BufferDepth = BlockSize * BeatsPerLine;
  // write slots held by the sink
  localparam int WriteCredits = 4;

  //////////////////////////////
  // vector types
  //////////////////////////////

  typedef logic [31:0] byteAddr_t;
  typedef logic [15:0] pixel_t;
  // lowest address pixel sits in the low bits
  typedef logic [63:0] pixelBeat_t;
  typedef logic [4:0]  blockIdx_t;
  typedef logic [3:0]  lineIdx_t;
  typedef logic [1:0]  beatIdx_t;
  typedef logic [5:0]  bufAddr_t;
  // 0 up to WriteCredits
  typedef logic [2:0]  creditCnt_t;

  //////////////////////////////
  // bundles
  //////////////////////////////

  typedef struct packed {
    byteAddr_t inBase;
    byteAddr_t outBase;
    blockIdx_t blocksX;
    blockIdx_t blocksY;
  } blockCmd_t;

  // one line read
  typedef struct packed {
    byteAddr_t addr;
  } rdReq_t;

  typedef struct packed {
    byteAddr_t  addr;
    pixelBeat_t data;
  } wrBeat_t;

  // both FSMs share the package scope, so literals carry a prefix
  typedef enum logic [1:0] {SeqIdle, SeqReadBlock, SeqWriteBlock, SeqFinish} seqState_t;
  typedef enum logic [2:0] {XferIdle, XferReqLine, XferWaitAck, XferRecvLine, XferDrain} xferState_t;

endpackage

// File: hdl/blockSequencer.sv
`timescale 1ns/1ps

module blockSequencer (
  input  logic                   Clk,
  input  logic                   reset,
  input  logic                   start,
  input  imageBlockPkg::blockCmd_t cmd,
  input  logic                   lastBlock,
  input  logic                   blockRead,
  input  logic                   blockWritten,
  output imageBlockPkg::blockCmd_t cmdReg,
  output logic                   readBlock,
  output logic                   writeBlock,
  output logic                   clearBlock,
  output logic                   advanceBlock,
  output logic                   busy,
  output logic                   done
);

  import imageBlockPkg::*;

  seqState_t state;

  //////////////////////////////
  // main FSM
  //////////////////////////////

  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= SeqIdle;
      readBlock <= 1'b0;
      writeBlock <= 1'b0;
      clearBlock <= 1'b0;
      advanceBlock <= 1'b0;
      done <= 1'b0;
    end else begin
      // all control outputs are single-cycle pulses
      readBlock <= 1'b0;
      writeBlock <= 1'b0;
      clearBlock <= 1'b0;
      advanceBlock <= 1'b0;
      done <= 1'b0;
      case (state)
        SeqIdle: begin
          if (start) begin
            // restart position at block 0,0 and fetch it
            clearBlock <= 1'b1;
            readBlock <= 1'b1;
            state <= SeqReadBlock;
          end
        end
        SeqReadBlock: begin
          // block is in the buffer and goes out next
          if (blockRead) begin
            writeBlock <= 1'b1;
            state <= SeqWriteBlock;
          end
        end
        SeqWriteBlock: begin
          if (blockWritten) begin
            if (lastBlock) begin
              done <= 1'b1;
              state <= SeqFinish;
            end else begin
              // counter steps to the next block with the read kick
              advanceBlock <= 1'b1;
              readBlock <= 1'b1;
              state <= SeqReadBlock;
            end
          end
        end
        SeqFinish: state <= SeqIdle;
        default: state <= SeqIdle;
      endcase
    end
  end

  // command held for the whole run
  always_ff @(posedge Clk) begin
    if (state == SeqIdle && start) begin
      cmdReg <= cmd;
    end
  end

  // Finish is the done cycle and counts as busy
  assign busy = (state != SeqIdle);

  // an empty image would never finish
  startSizeNonZero: assert property (@(posedge Clk) disable iff (reset)
    (state == SeqIdle && start) |-> (cmd.blocksX != '0 && cmd.blocksY != '0));

  // transfer engine answers only the step being waited on
  answerInState: assert property (@(posedge Clk) disable iff (reset)
    !(blockRead && state != SeqReadBlock) && !(blockWritten && state != SeqWriteBlock));

endmodule

// File: hdl/blockCounter.sv
`timescale 1ns/1ps

module blockCounter (
  input  logic                    Clk,
  input  logic                    reset,
  input  logic                    clear,
  input  logic                    advance,
  input  imageBlockPkg::blockIdx_t blocksX,
  input  imageBlockPkg::blockIdx_t blocksY,
  output imageBlockPkg::blockIdx_t blockX,
  output imageBlockPkg::blockIdx_t blockY,
  output logic                    lastBlock
);

  logic lastX;
  logic lastY;

  //////////////////////////////
  // end detection
  //////////////////////////////

  // compare stays in block index width
  assign lastX = (blockX == blocksX - 1'b1);
  assign lastY = (blockY == blocksY - 1'b1);
  assign lastBlock = lastX && lastY;

  //////////////////////////////
  // position
  //////////////////////////////

  always_ff @(posedge Clk) begin
    if (reset) begin
      blockX <= '0;
      blockY <= '0;
    end else if (clear) begin
      blockX <= '0;
      blockY <= '0;
    end else if (advance) begin
      // row by row, X runs fastest
      if (lastX) begin
        blockX <= '0;
        blockY <= blockY + 1'b1;
      end else begin
        blockX <= blockX + 1'b1;
      end
    end
  end

  // sequencer must stop at the final block
  noAdvancePastEnd: assert property (@(posedge Clk) disable iff (reset)
    advance |-> !lastBlock);

endmodule

// File: hdl/pixelBuffer.sv
`timescale 1ns/1ps

module pixelBuffer (
  input  logic                     Clk,
  input  logic                     wrEn,
  input  imageBlockPkg::bufAddr_t   wrAddr,
  input  imageBlockPkg::pixelBeat_t wrData,
  input  logic                     rdEn,
  input  imageBlockPkg::bufAddr_t   rdAddr,
  output imageBlockPkg::pixelBeat_t rdData
);

  import imageBlockPkg::*;

  // one word per beat, whole block
  pixelBeat_t mem [BufferDepth];

  //////////////////////////////
  // write port
  //////////////////////////////

  always_ff @(posedge Clk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // data one cycle after address, held while idle
  always_ff @(posedge Clk) begin
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

// File: hdl/lineTransfer.sv
`timescale 1ns/1ps

module lineTransfer (
  input  logic                     Clk,
  input  logic                     reset,
  input  logic                     readBlock,
  input  logic                     writeBlock,
  input  imageBlockPkg::blockCmd_t  cmd,
  input  imageBlockPkg::blockIdx_t  blockX,
  input  imageBlockPkg::blockIdx_t  blockY,
  input  logic                     rdCmdAck,
  input  logic                     rdBeatValid,
  input  imageBlockPkg::pixelBeat_t rdBeatData,
  input  imageBlockPkg::pixelBeat_t bufRdData,
  input  logic                     wrCredit,
  output logic                     rdReqValid,
  output imageBlockPkg::rdReq_t     rdReq,
  output logic                     bufWrEn,
  output imageBlockPkg::bufAddr_t   bufWrAddr,
  output imageBlockPkg::pixelBeat_t bufWrData,
  output logic                     bufRdEn,
  output imageBlockPkg::bufAddr_t   bufRdAddr,
  output logic                     wrBeatValid,
  output imageBlockPkg::wrBeat_t    wrBeat,
  output logic                     blockRead,
  output logic                     blockWritten
);

  import imageBlockPkg::*;

  xferState_t state;
  lineIdx_t   lineCnt;
  beatIdx_t   beatCnt;
  creditCnt_t creditCnt;
  byteAddr_t  wrAddrReg;
  logic       lastBeat;
  logic       lastLine;
  logic       commit;
  logic       drainDone;

  // byte address of a beat inside the current block
  function automatic byteAddr_t pixelAddr(byteAddr_t base, lineIdx_t line, beatIdx_t beat);
    byteAddr_t pitch;
    byteAddr_t row;
    byteAddr_t col;
    pitch = byteAddr_t'(cmd.blocksX) * BlockSize;
    row = byteAddr_t'(blockY) * BlockSize + byteAddr_t'(line);
    col = byteAddr_t'(blockX) * BlockSize + byteAddr_t'(beat) * PixelsPerBeat;
    return base + (row * pitch + col) * BytesPerPixel;
  endfunction

  assign lastBeat = (beatCnt == beatIdx_t'(BeatsPerLine - 1));
  assign lastLine = (lineCnt == lineIdx_t'(BlockSize - 1));

  //////////////////////////////
  // buffer ports
  //////////////////////////////

  // fill and drain never overlap, so one line/beat pair addresses both
  assign bufWrEn = (state == XferRecvLine) && rdBeatValid;
  assign bufWrAddr = {lineCnt, beatCnt};
  assign bufWrData = rdBeatData;

  // a commit is a buffer read backed by a credit
  assign commit = (state == XferDrain) && !drainDone && (creditCnt != '0);
  assign bufRdEn = commit;
  assign bufRdAddr = {lineCnt, beatCnt};

  //////////////////////////////
  // transfer FSM
  //////////////////////////////

  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= XferIdle;
      lineCnt <= '0;
      beatCnt <= '0;
      rdReqValid <= 1'b0;
      drainDone <= 1'b0;
      blockRead <= 1'b0;
      blockWritten <= 1'b0;
    end else begin
      blockRead <= 1'b0;
      blockWritten <= 1'b0;
      case (state)
        XferIdle: begin
          lineCnt <= '0;
          beatCnt <= '0;
          drainDone <= 1'b0;
          if (readBlock) begin
            state <= XferReqLine;
          end else if (writeBlock) begin
            state <= XferDrain;
          end
        end
        XferReqLine: begin
          // address registers alongside, see below
          rdReqValid <= 1'b1;
          state <= XferWaitAck;
        end
        XferWaitAck: begin
          // request held until the bus takes it
          if (rdCmdAck) begin
            rdReqValid <= 1'b0;
            state <= XferRecvLine;
          end
        end
        XferRecvLine: begin
          if (rdBeatValid) begin
            beatCnt <= beatCnt + 1'b1;
            if (lastBeat) begin
              if (lastLine) begin
                blockRead <= 1'b1;
                state <= XferIdle;
              end else begin
                lineCnt <= lineCnt + 1'b1;
                state <= XferReqLine;
              end
            end
          end
        end
        XferDrain: begin
          if (commit) begin
            beatCnt <= beatCnt + 1'b1;
            if (lastBeat) begin
              lineCnt <= lineCnt + 1'b1;
            end
            if (lastBeat && lastLine) begin
              drainDone <= 1'b1;
            end
          end
          // wait for the final beat to leave the output stage
          if (drainDone && !wrBeatValid) begin
            blockWritten <= 1'b1;
            state <= XferIdle;
          end
        end
        default: state <= XferIdle;
      endcase
    end
  end

  // line read address, beat 0
  always_ff @(posedge Clk) begin
    if (state == XferReqLine) begin
      rdReq.addr <= pixelAddr(cmd.inBase, lineCnt, '0);
    end
  end

  //////////////////////////////
  // write stream
  //////////////////////////////

  // address travels next to the buffer read
  always_ff @(posedge Clk) begin
    if (commit) begin
      wrAddrReg <= pixelAddr(cmd.outBase, lineCnt, beatCnt);
    end
  end

  always_ff @(posedge Clk) begin
    if (reset) begin
      wrBeatValid <= 1'b0;
      creditCnt <= creditCnt_t'(WriteCredits);
    end else begin
      wrBeatValid <= commit;
      // take and return may land together
      creditCnt <= creditCnt - creditCnt_t'(commit) + creditCnt_t'(wrCredit);
    end
  end

  // buffer data arrives in the same cycle as the valid
  assign wrBeat = '{addr: wrAddrReg, data: bufRdData};

  // sink never frees more slots than it has
  creditBound: assert property (@(posedge Clk) disable iff (reset)
    creditCnt <= creditCnt_t'(WriteCredits));

  beatOnlyInRecv: assert property (@(posedge Clk) disable iff (reset)
    rdBeatValid |-> (state == XferRecvLine));

endmodule

// File: hdl/imageBlockCopier.sv
`timescale 1ns/1ps

module imageBlockCopier (
  input  logic                     Clk,
  input  logic                     reset,
  input  logic                     start,
  input  imageBlockPkg::blockCmd_t  cmd,
  input  logic                     rdCmdAck,
  input  logic                     rdBeatValid,
  input  imageBlockPkg::pixelBeat_t rdBeatData,
  input  logic                     wrCredit,
  output logic                     busy,
  output logic                     done,
  output logic                     rdReqValid,
  output imageBlockPkg::rdReq_t     rdReq,
  output logic                     wrBeatValid,
  output imageBlockPkg::wrBeat_t    wrBeat
);

  import imageBlockPkg::*;

  // sequencer side
  blockCmd_t  cmdReg;
  logic       readBlock;
  logic       writeBlock;
  logic       clearBlock;
  logic       advanceBlock;
  logic       blockRead;
  logic       blockWritten;
  // position
  blockIdx_t  blockX;
  blockIdx_t  blockY;
  logic       lastBlock;
  // buffer
  logic       bufWrEn;
  bufAddr_t   bufWrAddr;
  pixelBeat_t bufWrData;
  logic       bufRdEn;
  bufAddr_t   bufRdAddr;
  pixelBeat_t bufRdData;

  blockSequencer i_blockSequencer (
    .Clk(Clk), .reset(reset), .start(start), .cmd(cmd), .lastBlock(lastBlock),
    .blockRead(blockRead), .blockWritten(blockWritten), .cmdReg(cmdReg),
    .readBlock(readBlock), .writeBlock(writeBlock), .clearBlock(clearBlock),
    .advanceBlock(advanceBlock), .busy(busy), .done(done)
  );

  blockCounter i_blockCounter (
    .Clk(Clk), .reset(reset), .clear(clearBlock), .advance(advanceBlock),
    .blocksX(cmdReg.blocksX), .blocksY(cmdReg.blocksY),
    .blockX(blockX), .blockY(blockY), .lastBlock(lastBlock)
  );

  lineTransfer i_lineTransfer (
    .Clk(Clk), .reset(reset), .readBlock(readBlock), .writeBlock(writeBlock),
    .cmd(cmdReg), .blockX(blockX), .blockY(blockY), .rdCmdAck(rdCmdAck),
    .rdBeatValid(rdBeatValid), .rdBeatData(rdBeatData), .bufRdData(bufRdData),
    .wrCredit(wrCredit), .rdReqValid(rdReqValid), .rdReq(rdReq),
    .bufWrEn(bufWrEn), .bufWrAddr(bufWrAddr), .bufWrData(bufWrData),
    .bufRdEn(bufRdEn), .bufRdAddr(bufRdAddr), .wrBeatValid(wrBeatValid),
    .wrBeat(wrBeat), .blockRead(blockRead), .blockWritten(blockWritten)
  );

  pixelBuffer i_pixelBuffer (
    .Clk(Clk), .wrEn(bufWrEn), .wrAddr(bufWrAddr), .wrData(bufWrData),
    .rdEn(bufRdEn), .rdAddr(bufRdAddr), .rdData(bufRdData)
  );

endmodule

// File: verification/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic Clk,
  output logic porReset
);

  // 4 ns period
  initial Clk = 1'b0;
  always #2 Clk = ~Clk;

  // power-on reset held for 8 cycles
  initial begin
    porReset <= 1'b1;
    repeat (8) @(posedge Clk);
    porReset <= 1'b0;
  end

endmodule

// File: verification/imageBlockCopierTb.sv
`timescale 1ns/1ps

module imageBlockCopierTb;

  import imageBlockPkg::*;

  //////////////////////////////
  // run limits
  //////////////////////////////

  // worst-case beats over all tests rounded up
  localparam int TotalBeats = 1024;
  // longest credit hold stretch in cycles
  localparam int MaxDelayCycles = 40;
  localparam int ClkPeriodNs = 4;
  localparam longint WatchdogNs = 2 * TotalBeats * MaxDelayCycles * ClkPeriodNs;

  logic       Clk;
  logic       porReset;
  logic       midReset;
  logic       reset;
  logic       start;
  blockCmd_t  cmd;
  logic       rdCmdAck;
  logic       rdBeatValid;
  pixelBeat_t rdBeatData;
  logic       wrCredit;
  logic       busy;
  logic       done;
  logic       rdReqValid;
  rdReq_t     rdReq;
  logic       wrBeatValid;
  wrBeat_t    wrBeat;

  integer     seed = 32'hbf0a_967f;
  int         errors = 0;
  int         testsRun = 0;
  blockCmd_t  curCmd;
  // stimulus knobs
  logic       holdMode = 1'b0;
  // model and sink state
  int         memState = 0;
  int         ackWait;
  int         beatsLeft;
  byteAddr_t  beatAddr;
  byteAddr_t  expAddr;
  int         reqCount = 0;
  int         beatCount = 0;
  int         outstanding = 0;
  logic       holding = 1'b0;
  int         holdTimer = 0;

  assign reset = porReset | midReset;

  tbClock i_tbClock (.Clk(Clk), .porReset(porReset));

  imageBlockCopier i_dut (
    .Clk(Clk), .reset(reset), .start(start), .cmd(cmd), .rdCmdAck(rdCmdAck),
    .rdBeatValid(rdBeatValid), .rdBeatData(rdBeatData), .wrCredit(wrCredit),
    .busy(busy), .done(done), .rdReqValid(rdReqValid), .rdReq(rdReq),
    .wrBeatValid(wrBeatValid), .wrBeat(wrBeat)
  );

  //////////////////////////////
  // reference model
  //////////////////////////////

  // source image content at one byte address
  function automatic pixel_t pixelValue(byteAddr_t a);
    pixel_t low;
    low = a[15:0];
    return (low >> 1) ^ 16'h5a3c;
  endfunction

  function automatic pixelBeat_t beatAt(byteAddr_t a);
    pixelBeat_t b;
    for (int i = 0; i < PixelsPerBeat; i++) begin
      b[16*i +: 16] = pixelValue(a + byteAddr_t'(BytesPerPixel * i));
    end
    return b;
  endfunction

  // beat address with blocks counted row by row
  function automatic byteAddr_t lineAddr(byteAddr_t base, int blk, int line, int beat);
    int bx;
    int by;
    int pitch;
    int pix;
    bx = blk % int'(curCmd.blocksX);
    by = blk / int'(curCmd.blocksX);
    pitch = int'(curCmd.blocksX) * BlockSize;
    pix = (by * BlockSize + line) * pitch + bx * BlockSize + beat * PixelsPerBeat;
    return base + byteAddr_t'(pix * BytesPerPixel);
  endfunction

  // output beat mapped back into the input image
  function automatic pixelBeat_t refBeat(byteAddr_t outAddr);
    byteAddr_t inAddr;
    inAddr = curCmd.inBase + (outAddr - curCmd.outBase);
    return beatAt(inAddr);
  endfunction

  task automatic checkValue(input string name, input logic [95:0] got, input logic [95:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////
  // source memory model
  //////////////////////////////

  always @(negedge Clk) begin
    if (reset) begin
      memState = 0;
      reqCount = 0;
      rdCmdAck <= 1'b0;
      rdBeatValid <= 1'b0;
      rdBeatData <= '0;
    end else begin
      case (memState)
        0: begin
          rdCmdAck <= 1'b0;
          rdBeatValid <= 1'b0;
          if (rdReqValid) begin
            checkValue("rdReq.addr", rdReq.addr,
              lineAddr(curCmd.inBase, reqCount / BlockSize, reqCount % BlockSize, 0));
            beatAddr = rdReq.addr;
            reqCount++;
            ackWait = $unsigned($random(seed)) % 5;
            memState = 1;
          end
        end
        1: begin
          // request must stay up until the ack
          if (!rdReqValid) begin
            $display("read request dropped before it was acknowledged");
            errors++;
          end
          if (ackWait == 0) begin
            rdCmdAck <= 1'b1;
            beatsLeft = BeatsPerLine;
            memState = 2;
          end else begin
            ackWait--;
          end
        end
        default: begin
          rdCmdAck <= 1'b0;
          // random gaps between beats
          if ($unsigned($random(seed)) % 3 != 0) begin
            rdBeatValid <= 1'b1;
            rdBeatData <= beatAt(beatAddr);
            beatAddr = beatAddr + byteAddr_t'(PixelsPerBeat * BytesPerPixel);
            beatsLeft--;
            if (beatsLeft == 0) begin
              memState = 0;
            end
          end else begin
            rdBeatValid <= 1'b0;
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // write sink and compare
  //////////////////////////////

  always @(negedge Clk) begin
    if (reset) begin
      beatCount = 0;
      outstanding = 0;
      wrCredit <= 1'b0;
    end else begin
      if (wrBeatValid) begin
        expAddr = lineAddr(curCmd.outBase, beatCount / BufferDepth,
          (beatCount % BufferDepth) / BeatsPerLine, beatCount % BeatsPerLine);
        checkValue("wrBeat.addr", wrBeat.addr, expAddr);
        checkValue("wrBeat.data", wrBeat.data, refBeat(expAddr));
        beatCount++;
        outstanding++;
        if (outstanding > WriteCredits) begin
          $display("more write beats outstanding than the sink has credits for");
          errors++;
        end
      end
      // long stretches with no credits returned
      if (holdMode) begin
        if (holdTimer == 0) begin
          holding = !holding;
          holdTimer = 20 + $unsigned($random(seed)) % 20;
        end else begin
          holdTimer--;
        end
      end else begin
        holding = 1'b0;
      end
      if (outstanding > 0 && !holding && $unsigned($random(seed)) % 3 == 0) begin
        wrCredit <= 1'b1;
        outstanding--;
      end else begin
        wrCredit <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // test tasks
  //////////////////////////////

  task automatic sendStart(input blockCmd_t c);
    @(negedge Clk);
    curCmd = c;
    // request and beat positions count from the new command
    reqCount = 0;
    beatCount = 0;
    cmd <= c;
    start <= 1'b1;
    @(negedge Clk);
    start <= 1'b0;
  endtask

  // one full copy with an optional stray start while busy
  task automatic runCopy(input string name, input blockCmd_t c, input logic extraStart);
    int errsBefore;
    int doneSeen;
    blockCmd_t stray;
    errsBefore = errors;
    doneSeen = 0;
    stray = '{inBase: 32'h0009_0000, outBase: 32'h000a_0000, blocksX: 5'd7, blocksY: 5'd7};
    sendStart(c);
    if (extraStart) begin
      repeat (10) @(negedge Clk);
      cmd <= stray;
      start <= 1'b1;
      @(negedge Clk);
      start <= 1'b0;
      cmd <= c;
    end
    while (!done) begin
      @(negedge Clk);
    end
    doneSeen++;
    @(negedge Clk);
    checkValue("busy", busy, 1'b0);
    repeat (20) begin
      if (done) begin
        doneSeen++;
      end
      if (busy) begin
        $display("DUT became busy again with no new command");
        errors++;
      end
      @(negedge Clk);
    end
    checkValue("done count", doneSeen, 1);
    checkValue("beat count", beatCount, int'(c.blocksX) * int'(c.blocksY) * BufferDepth);
    testsRun++;
    $display("Test %0d %s: %0d errors", testsRun, name, errors - errsBefore);
  endtask

  // reset pulse at a chosen point of a one-block copy
  task automatic resetMidRun(input string name, input int waitFor);
    int errsBefore;
    errsBefore = errors;
    sendStart('{inBase: 32'h000b_0000, outBase: 32'h000c_0000, blocksX: 5'd1, blocksY: 5'd1});
    // 0 read request, 1 write stream, 2 done pulse
    while (!(waitFor == 0 ? rdReqValid : (waitFor == 1 ? wrBeatValid : done))) begin
      @(negedge Clk);
    end
    midReset <= 1'b1;
    @(negedge Clk);
    checkValue("rdReqValid", rdReqValid, 1'b0);
    checkValue("wrBeatValid", wrBeatValid, 1'b0);
    checkValue("busy", busy, 1'b0);
    checkValue("done", done, 1'b0);
    midReset <= 1'b0;
    @(negedge Clk);
    testsRun++;
    $display("Test %0d %s: %0d errors", testsRun, name, errors - errsBefore);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    midReset <= 1'b0;
    start <= 1'b0;
    cmd <= '0;
    curCmd = '0;
    rdCmdAck <= 1'b0;
    rdBeatValid <= 1'b0;
    rdBeatData <= '0;
    wrCredit <= 1'b0;
    @(negedge porReset);
    @(negedge Clk);

    runCopy("single block", '{inBase: 32'h0001_0000, outBase: 32'h0002_0000,
      blocksX: 5'd1, blocksY: 5'd1}, 1'b0);
    runCopy("3x2 image", '{inBase: 32'h0003_0400, outBase: 32'h0005_0000,
      blocksX: 5'd3, blocksY: 5'd2}, 1'b0);
    holdMode = 1'b1;
    runCopy("back-pressure", '{inBase: 32'h0006_0000, outBase: 32'h0007_8000,
      blocksX: 5'd2, blocksY: 5'd1}, 1'b0);
    holdMode = 1'b0;
    runCopy("start while busy", '{inBase: 32'h0008_0000, outBase: 32'h0008_4000,
      blocksX: 5'd1, blocksY: 5'd1}, 1'b1);

    resetMidRun("reset during read request", 0);
    resetMidRun("reset during write stream", 1);
    resetMidRun("reset on done", 2);
    runCopy("copy after reset", '{inBase: 32'h000d_0000, outBase: 32'h000e_0000,
      blocksX: 5'd1, blocksY: 5'd1}, 1'b0);

    $display("%0d tests run, %0d errors", testsRun, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // hard stop if a handshake never completes
  initial begin
    #(WatchdogNs);
    $display("watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: imageBlockCopier.f
hdl/imageBlockPkg.sv
hdl/blockSequencer.sv
hdl/blockCounter.sv
hdl/pixelBuffer.sv
hdl/lineTransfer.sv
hdl/imageBlockCopier.sv
verification/tbClock.sv
verification/imageBlockCopierTb.sv

// File: Makefile
# Verilator build and run for the image block copier

VERILATOR ?= verilator
TOP       ?= imageBlockCopierTb
FLIST     ?= imageBlockCopier.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
